// File: ptp_pkg.sv
// PTP definitions shared by the MAC adaptation layer.
//   Timestamp and tag widths.
//   Timestamp and tag types.
//   Transmit timestamp report, a timestamp paired with its tag.

package ptp_pkg;

    localparam int TS_W  = 96;
    localparam int TAG_W = 8;

    typedef logic [TS_W-1:0]  ptp_ts_t;
    typedef logic [TAG_W-1:0] ptp_tag_t;

    // Egress timestamp as returned by the MAC.
    typedef struct packed {
        ptp_ts_t  ts;
        ptp_tag_t tag;
    } ts_report_t;

endpackage

// File: mac_if_pkg.sv
// Stream definitions for the MAC adaptation layer.
//   Channel count, stream widths and reset synchroniser depth.
//   User transmit and receive AXI-Stream beats.
//   MAC-side packet-stream (AVST) beat.

package mac_if_pkg;

    localparam int N_CH       = 2;
    localparam int DATA_W     = 64;
    localparam int KEEP_W     = DATA_W / 8;
    localparam int EMPTY_W    = 3;
    localparam int ERR_W      = 6;
    localparam int RST_STAGES = 4;

    // User transmit beat with err and tag in the sideband.
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
        logic              err;
        ptp_pkg::ptp_tag_t tag;
    } tx_axis_t;

    // User receive beat with ingress timestamp.
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
        logic              err;
        ptp_pkg::ptp_ts_t  ts;
    } rx_axis_t;

    // MAC-side beat with the first byte in the top lane.
    typedef struct packed {
        logic [DATA_W-1:0]  data;
        logic               sop;
        logic               eop;
        logic [EMPTY_W-1:0] empty;
        logic [ERR_W-1:0]   error;
    } avst_t;

endpackage

// File: mac_reset_sync.sv
// Per-channel MAC reset generator.
//   Held while global reset is high or a lane flag is low,
//   then released after a fixed number of clean cycles.

`timescale 1ns/1ps

module mac_reset_sync (
    input  logic i_mac_clk,
    input  logic i_rst,
    input  logic i_lanes_stable,
    input  logic i_ehip_ready,
    output logic o_mac_rst
);

    logic                              rst_cause;
    logic [mac_if_pkg::RST_STAGES-1:0] rst_sr;

    assign rst_cause = i_rst || !i_lanes_stable || !i_ehip_ready;

    // Load ones on any cause, drain with zeros.
    always_ff @(posedge i_mac_clk) begin
        if (rst_cause) begin
            rst_sr <= '1;
        end else begin
            rst_sr <= {rst_sr[mac_if_pkg::RST_STAGES-2:0], 1'b0};
        end
    end

    assign o_mac_rst = rst_sr[mac_if_pkg::RST_STAGES-1];

endmodule

// File: mac_tx_axis2avst.sv
// Transmit AXI-Stream to packet-stream converter.
//   Generates sop from frame state and eop from tlast.
//   Reverses byte order and derives empty from tkeep.
//   Maps the user error bit onto error bit 0.

`timescale 1ns/1ps

module mac_tx_axis2avst (
    input  logic                 i_mac_clk,
    input  logic                 i_rst,
    input  mac_if_pkg::tx_axis_t i_axis,
    input  logic                 i_valid,
    output logic                 o_ready,
    output mac_if_pkg::avst_t    o_avst,
    output logic                 o_avst_valid,
    input  logic                 i_avst_ready
);

    logic                         in_frame;
    logic [mac_if_pkg::EMPTY_W:0] keep_cnt;
    logic [mac_if_pkg::EMPTY_W:0] empty_full;

    // The MAC paces the user stream directly.
    assign o_ready      = i_avst_ready;
    assign o_avst_valid = i_valid && !i_rst;

    // Cleared after tlast, so the next beat carries sop.
    always_ff @(posedge i_mac_clk) begin
        if (i_rst) begin
            in_frame <= 1'b0;
        end else if (i_valid && i_avst_ready) begin
            in_frame <= !i_axis.tlast;
        end
    end

    // Count of valid byte lanes.
    always_comb begin
        keep_cnt = '0;
        for (int i = 0; i < mac_if_pkg::KEEP_W; i++) begin
            keep_cnt = keep_cnt + {{mac_if_pkg::EMPTY_W{1'b0}}, i_axis.tkeep[i]};
        end
    end

    assign empty_full = (mac_if_pkg::EMPTY_W+1)'(mac_if_pkg::KEEP_W) - keep_cnt;

    always_comb begin
        o_avst = '0;
        // Lane 0 goes to the top byte.
        for (int i = 0; i < mac_if_pkg::KEEP_W; i++) begin
            o_avst.data[(mac_if_pkg::KEEP_W-1-i)*8 +: 8] = i_axis.tdata[i*8 +: 8];
        end
        o_avst.sop   = !in_frame;
        o_avst.eop   = i_axis.tlast;
        o_avst.empty = empty_full[mac_if_pkg::EMPTY_W-1:0];
        o_avst.error = {{(mac_if_pkg::ERR_W-1){1'b0}}, i_axis.err};
    end

endmodule

// File: mac_rx_avst2axis.sv
// Receive packet-stream to AXI-Stream converter.
//   One register stage, no back-pressure from the user side.
//   Reverses byte order, rebuilds tkeep from empty on eop,
//   folds the error field into a single err bit.

`timescale 1ns/1ps

module mac_rx_avst2axis (
    input  logic                 i_mac_clk,
    input  logic                 i_rst,
    input  mac_if_pkg::avst_t    i_avst,
    input  logic                 i_valid,
    output mac_if_pkg::rx_axis_t o_axis,
    output logic                 o_valid
);

    mac_if_pkg::rx_axis_t axis_d;

    always_comb begin
        axis_d = '0;
        for (int i = 0; i < mac_if_pkg::KEEP_W; i++) begin
            axis_d.tdata[i*8 +: 8] = i_avst.data[(mac_if_pkg::KEEP_W-1-i)*8 +: 8];
        end
        // Only the last beat may be partial.
        if (i_avst.eop) begin
            axis_d.tkeep = {mac_if_pkg::KEEP_W{1'b1}} >> i_avst.empty;
        end else begin
            axis_d.tkeep = {mac_if_pkg::KEEP_W{1'b1}};
        end
        axis_d.tlast = i_avst.eop;
        axis_d.err   = |i_avst.error;
        // Timestamp is filled downstream.
        axis_d.ts    = '0;
    end

    always_ff @(posedge i_mac_clk) begin
        if (i_valid) begin
            o_axis <= axis_d;
        end
    end

    always_ff @(posedge i_mac_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

endmodule

// File: mac_rx_ts_insert.sv
// Receive timestamp insertion.
//   Captures the ingress timestamp on the first beat of a frame
//   and attaches it to every beat of that frame.

`timescale 1ns/1ps

module mac_rx_ts_insert (
    input  logic                 i_mac_clk,
    input  logic                 i_rst,
    input  ptp_pkg::ptp_ts_t     i_ts,
    input  mac_if_pkg::rx_axis_t i_axis,
    input  logic                 i_valid,
    output mac_if_pkg::rx_axis_t o_axis,
    output logic                 o_valid
);

    logic             in_frame;
    ptp_pkg::ptp_ts_t ts_q;

    always_ff @(posedge i_mac_clk) begin
        if (i_rst) begin
            in_frame <= 1'b0;
        end else if (i_valid) begin
            in_frame <= !i_axis.tlast;
        end
    end

    // Hold the first-beat timestamp for the rest of the frame.
    always_ff @(posedge i_mac_clk) begin
        if (i_valid && !in_frame) begin
            ts_q <= i_ts;
        end
    end

    always_comb begin
        o_axis    = i_axis;
        o_axis.ts = in_frame ? ts_q : i_ts;
    end

    assign o_valid = i_valid && !i_rst;

endmodule

// File: mac_channel.sv
// One MAC channel of the adaptation layer.
//   Channel reset from global reset and lane status.
//   Transmit conversion with tag forwarding to the MAC.
//   Receive conversion followed by timestamp insertion.
//   Egress timestamp report back to the user side.

`timescale 1ns/1ps

module mac_channel (
    input  logic                   i_mac_clk,
    input  logic                   i_rst,
    input  logic                   i_lanes_stable,
    input  logic                   i_ehip_ready,

    input  mac_if_pkg::tx_axis_t   i_tx_axis,
    input  logic                   i_tx_valid,
    output logic                   o_tx_ready,
    output mac_if_pkg::avst_t      o_tx_avst,
    output logic                   o_tx_avst_valid,
    input  logic                   i_tx_avst_ready,
    output ptp_pkg::ptp_tag_t      o_tx_fp,

    input  ptp_pkg::ts_report_t    i_tx_ts_report,
    input  logic                   i_tx_ts_report_valid,
    output ptp_pkg::ts_report_t    o_tx_ts_report,
    output logic                   o_tx_ts_report_valid,

    input  mac_if_pkg::avst_t      i_rx_avst,
    input  logic                   i_rx_avst_valid,
    input  ptp_pkg::ptp_ts_t       i_rx_ts,
    output mac_if_pkg::rx_axis_t   o_rx_axis,
    output logic                   o_rx_valid,

    output logic                   o_mac_rst
);

    logic                 mac_rst;
    mac_if_pkg::rx_axis_t rx_axis_int;
    logic                 rx_valid_int;

    mac_reset_sync reset_sync_i (
        .i_mac_clk      (i_mac_clk),
        .i_rst          (i_rst),
        .i_lanes_stable (i_lanes_stable),
        .i_ehip_ready   (i_ehip_ready),
        .o_mac_rst      (mac_rst)
    );

    mac_tx_axis2avst tx_axis2avst_i (
        .i_mac_clk    (i_mac_clk),
        .i_rst        (mac_rst),
        .i_axis       (i_tx_axis),
        .i_valid      (i_tx_valid),
        .o_ready      (o_tx_ready),
        .o_avst       (o_tx_avst),
        .o_avst_valid (o_tx_avst_valid),
        .i_avst_ready (i_tx_avst_ready)
    );

    // The MAC takes the tag alongside each beat.
    assign o_tx_fp = i_tx_axis.tag;

    assign o_tx_ts_report       = i_tx_ts_report;
    assign o_tx_ts_report_valid = i_tx_ts_report_valid && !mac_rst;

    mac_rx_avst2axis rx_avst2axis_i (
        .i_mac_clk (i_mac_clk),
        .i_rst     (mac_rst),
        .i_avst    (i_rx_avst),
        .i_valid   (i_rx_avst_valid),
        .o_axis    (rx_axis_int),
        .o_valid   (rx_valid_int)
    );

    mac_rx_ts_insert rx_ts_insert_i (
        .i_mac_clk (i_mac_clk),
        .i_rst     (mac_rst),
        .i_ts      (i_rx_ts),
        .i_axis    (rx_axis_int),
        .i_valid   (rx_valid_int),
        .o_axis    (o_rx_axis),
        .o_valid   (o_rx_valid)
    );

    assign o_mac_rst = mac_rst;

endmodule

// File: mac_dual_wrapper.sv
// Dual-channel MAC adaptation layer top level.
//   Two identical channels on one MAC clock and one global reset.
//   Per-channel ports are packed arrays indexed by channel.

`timescale 1ns/1ps

module mac_dual_wrapper (
    input  logic                                               i_mac_clk,
    input  logic                                               i_rst,
    input  logic                 [mac_if_pkg::N_CH-1:0]        i_lanes_stable,
    input  logic                 [mac_if_pkg::N_CH-1:0]        i_ehip_ready,

    input  mac_if_pkg::tx_axis_t [mac_if_pkg::N_CH-1:0]        i_tx_axis,
    input  logic                 [mac_if_pkg::N_CH-1:0]        i_tx_valid,
    output logic                 [mac_if_pkg::N_CH-1:0]        o_tx_ready,
    output mac_if_pkg::avst_t    [mac_if_pkg::N_CH-1:0]        o_tx_avst,
    output logic                 [mac_if_pkg::N_CH-1:0]        o_tx_avst_valid,
    input  logic                 [mac_if_pkg::N_CH-1:0]        i_tx_avst_ready,
    output ptp_pkg::ptp_tag_t    [mac_if_pkg::N_CH-1:0]        o_tx_fp,

    input  ptp_pkg::ts_report_t  [mac_if_pkg::N_CH-1:0]        i_tx_ts_report,
    input  logic                 [mac_if_pkg::N_CH-1:0]        i_tx_ts_report_valid,
    output ptp_pkg::ts_report_t  [mac_if_pkg::N_CH-1:0]        o_tx_ts_report,
    output logic                 [mac_if_pkg::N_CH-1:0]        o_tx_ts_report_valid,

    input  mac_if_pkg::avst_t    [mac_if_pkg::N_CH-1:0]        i_rx_avst,
    input  logic                 [mac_if_pkg::N_CH-1:0]        i_rx_avst_valid,
    input  ptp_pkg::ptp_ts_t     [mac_if_pkg::N_CH-1:0]        i_rx_ts,
    output mac_if_pkg::rx_axis_t [mac_if_pkg::N_CH-1:0]        o_rx_axis,
    output logic                 [mac_if_pkg::N_CH-1:0]        o_rx_valid,

    output logic                 [mac_if_pkg::N_CH-1:0]        o_mac_rst
);

    for (genvar n = 0; n < mac_if_pkg::N_CH; n++) begin : g_ch
        mac_channel channel_i (
            .i_mac_clk            (i_mac_clk),
            .i_rst                (i_rst),
            .i_lanes_stable       (i_lanes_stable[n]),
            .i_ehip_ready         (i_ehip_ready[n]),
            .i_tx_axis            (i_tx_axis[n]),
            .i_tx_valid           (i_tx_valid[n]),
            .o_tx_ready           (o_tx_ready[n]),
            .o_tx_avst            (o_tx_avst[n]),
            .o_tx_avst_valid      (o_tx_avst_valid[n]),
            .i_tx_avst_ready      (i_tx_avst_ready[n]),
            .o_tx_fp              (o_tx_fp[n]),
            .i_tx_ts_report       (i_tx_ts_report[n]),
            .i_tx_ts_report_valid (i_tx_ts_report_valid[n]),
            .o_tx_ts_report       (o_tx_ts_report[n]),
            .o_tx_ts_report_valid (o_tx_ts_report_valid[n]),
            .i_rx_avst            (i_rx_avst[n]),
            .i_rx_avst_valid      (i_rx_avst_valid[n]),
            .i_rx_ts              (i_rx_ts[n]),
            .o_rx_axis            (o_rx_axis[n]),
            .o_rx_valid           (o_rx_valid[n]),
            .o_mac_rst            (o_mac_rst[n])
        );
    end

endmodule

// File: tb_mac_dual_wrapper.sv
// Testbench for the dual-channel MAC adaptation layer.
//   Plays the user side and the MAC side of both channels.
//   Reference models for transmit and receive beats.
//   Compare process, reset gating check and cycle timeout.

`timescale 1ns/1ps

module tb_mac_dual_wrapper;

    localparam int NC      = mac_if_pkg::N_CH;
    localparam int KW      = mac_if_pkg::KEEP_W;
    localparam int TIMEOUT = 20000;

    logic                                  i_mac_clk;
    logic                                  i_rst;
    logic                 [NC-1:0]         i_lanes_stable;
    logic                 [NC-1:0]         i_ehip_ready;
    mac_if_pkg::tx_axis_t [NC-1:0]         i_tx_axis;
    logic                 [NC-1:0]         i_tx_valid;
    logic                 [NC-1:0]         o_tx_ready;
    mac_if_pkg::avst_t    [NC-1:0]         o_tx_avst;
    logic                 [NC-1:0]         o_tx_avst_valid;
    logic                 [NC-1:0]         i_tx_avst_ready;
    ptp_pkg::ptp_tag_t    [NC-1:0]         o_tx_fp;
    ptp_pkg::ts_report_t  [NC-1:0]         i_tx_ts_report;
    logic                 [NC-1:0]         i_tx_ts_report_valid;
    ptp_pkg::ts_report_t  [NC-1:0]         o_tx_ts_report;
    logic                 [NC-1:0]         o_tx_ts_report_valid;
    mac_if_pkg::avst_t    [NC-1:0]         i_rx_avst;
    logic                 [NC-1:0]         i_rx_avst_valid;
    ptp_pkg::ptp_ts_t     [NC-1:0]         i_rx_ts;
    mac_if_pkg::rx_axis_t [NC-1:0]         o_rx_axis;
    logic                 [NC-1:0]         o_rx_valid;
    logic                 [NC-1:0]         o_mac_rst;

    logic [31:0] lfsr = 32'haaa8a379;
    string       test_name = "init";
    int          cyc = 0;
    logic        bp_on;
    logic [NC-1:0] rep_on;
    // Channels whose outputs are expected to be quiet.
    logic [NC-1:0] held;

    mac_if_pkg::tx_axis_t tx_sent_q[NC][$];
    mac_if_pkg::avst_t    rx_exp_q[NC][$];
    int                   rx_cyc_q[NC][$];
    logic                 tx_in_fr[NC];
    logic                 rx_in_fr[NC];
    ptp_pkg::ptp_ts_t     rx_ts_hold[NC];

    mac_dual_wrapper dut_i (.*);

    function automatic logic [63:0] rnd(input int n);
        logic        fb;
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    // Expected MAC-side beat for one user beat.
    function automatic mac_if_pkg::avst_t ref_tx(input mac_if_pkg::tx_axis_t b,
                                                 input logic in_fr);
        mac_if_pkg::avst_t a;
        int                n;
        a = '0;
        n = 0;
        for (int i = 0; i < KW; i++) begin
            a.data[(KW-1-i)*8 +: 8] = b.tdata[i*8 +: 8];
            n = n + int'(b.tkeep[i]);
        end
        a.sop   = !in_fr;
        a.eop   = b.tlast;
        a.empty = 3'((KW - n) % KW);
        a.error = {5'b0, b.err};
        return a;
    endfunction

    // Expected user beat for one MAC-side beat.
    function automatic mac_if_pkg::rx_axis_t ref_rx(input mac_if_pkg::avst_t a,
                                                    input ptp_pkg::ptp_ts_t ts);
        mac_if_pkg::rx_axis_t r;
        int                   nb;
        r  = '0;
        nb = a.eop ? KW - int'(a.empty) : KW;
        for (int i = 0; i < KW; i++) begin
            r.tdata[i*8 +: 8] = a.data[(KW-1-i)*8 +: 8];
            r.tkeep[i]        = (i < nb);
        end
        r.tlast = a.eop;
        r.err   = (a.error != 6'd0);
        r.ts    = ts;
        return r;
    endfunction

    task automatic report_value_error(input string what, input string exp_s, input string act_s);
        $display("mismatch test=%s %s expected=%s actual=%s", test_name, what, exp_s, act_s);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("error in test %s: %s", test_name, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic send_tx_frame(input int c);
        int                   nb;
        mac_if_pkg::tx_axis_t b;
        logic                 acc;
        nb = 1 + int'(rnd(3));
        for (int k = 0; k < nb; k++) begin
            b.tdata = rnd(64);
            b.tlast = (k == nb - 1);
            b.tkeep = b.tlast ? 8'(8'hff >> rnd(3)) : 8'hff;
            b.err   = 1'(rnd(1));
            b.tag   = 8'(rnd(8));
            tx_sent_q[c].push_back(b);
            i_tx_axis[c]  = b;
            i_tx_valid[c] = 1'b1;
            acc = 1'b0;
            while (!acc) begin
                @(posedge i_mac_clk);
                acc = i_tx_avst_ready[c];
            end
            @(negedge i_mac_clk);
        end
        i_tx_valid[c] = 1'b0;
        repeat (int'(rnd(2))) @(negedge i_mac_clk);
    endtask

    task automatic send_rx_frame(input int c);
        int                nb;
        mac_if_pkg::avst_t a;
        nb = 1 + int'(rnd(3));
        for (int k = 0; k < nb; k++) begin
            a.data  = rnd(64);
            a.sop   = (k == 0);
            a.eop   = (k == nb - 1);
            a.empty = a.eop ? 3'(rnd(3)) : 3'd0;
            a.error = (rnd(2) == 64'd0) ? 6'(rnd(6)) : 6'd0;
            i_rx_avst[c]       = a;
            i_rx_avst_valid[c] = 1'b1;
            @(negedge i_mac_clk);
        end
        i_rx_avst_valid[c] = 1'b0;
        repeat (int'(rnd(2))) @(negedge i_mac_clk);
    endtask

    initial begin
        i_mac_clk = 1'b0;
        forever #5 i_mac_clk = ~i_mac_clk;
    end

    // MAC-side model drives ready, ingress time and egress reports.
    initial begin
        forever begin
            @(negedge i_mac_clk);
            for (int c = 0; c < NC; c++) begin
                i_tx_avst_ready[c]      = bp_on ? 1'(rnd(1)) : 1'b1;
                i_rx_ts[c]              = {32'(rnd(32)), 32'(rnd(32)), 32'(rnd(32))};
                i_tx_ts_report[c].ts    = {32'(rnd(32)), 32'(rnd(32)), 32'(rnd(32))};
                i_tx_ts_report[c].tag   = 8'(rnd(8));
                i_tx_ts_report_valid[c] = rep_on[c] && 1'(rnd(1));
            end
        end
    end

    // Compare process samples on the rising edge.
    initial begin
        mac_if_pkg::tx_axis_t b;
        mac_if_pkg::avst_t    ea;
        mac_if_pkg::rx_axis_t er;
        int                   cy;
        forever begin
            @(posedge i_mac_clk);
            cyc++;
            if (cyc >= TIMEOUT) begin
                $display("timeout: run did not finish within %0d cycles", TIMEOUT);
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
            for (int c = 0; c < NC; c++) begin
                if (held[c]) begin
                    tx_in_fr[c] = 1'b0;
                    rx_in_fr[c] = 1'b0;
                end else begin
                    assert (!o_mac_rst[c]) else
                        report_failure("channel reset high while the channel should be running");
                end
                assert (o_tx_ready[c] == i_tx_avst_ready[c]) else
                    report_value_error("tx ready", $sformatf("%b", i_tx_avst_ready[c]),
                                       $sformatf("%b", o_tx_ready[c]));
                assert (o_tx_avst_valid[c] == (i_tx_valid[c] && !held[c])) else
                    report_value_error("tx valid", $sformatf("%b", i_tx_valid[c] && !held[c]),
                                       $sformatf("%b", o_tx_avst_valid[c]));
                if (o_tx_avst_valid[c] && i_tx_avst_ready[c]) begin
                    if (tx_sent_q[c].size() == 0) begin
                        report_failure("transmit beat accepted with nothing sent");
                    end else begin
                        b  = tx_sent_q[c].pop_front();
                        ea = ref_tx(b, tx_in_fr[c]);
                        assert (o_tx_avst[c] == ea) else
                            report_value_error("tx beat", $sformatf("%h", ea),
                                               $sformatf("%h", o_tx_avst[c]));
                        assert (o_tx_fp[c] == b.tag) else
                            report_value_error("tx tag", $sformatf("%h", b.tag),
                                               $sformatf("%h", o_tx_fp[c]));
                        tx_in_fr[c] = !b.tlast;
                    end
                end
                assert (o_tx_ts_report[c] == i_tx_ts_report[c]) else
                    report_value_error("ts report", $sformatf("%h", i_tx_ts_report[c]),
                                       $sformatf("%h", o_tx_ts_report[c]));
                assert (o_tx_ts_report_valid[c] == (i_tx_ts_report_valid[c] && !held[c])) else
                    report_value_error("ts report valid",
                                       $sformatf("%b", i_tx_ts_report_valid[c] && !held[c]),
                                       $sformatf("%b", o_tx_ts_report_valid[c]));
                if (o_rx_valid[c]) begin
                    if (rx_exp_q[c].size() == 0) begin
                        report_failure("receive beat appeared with nothing sent");
                    end else begin
                        ea = rx_exp_q[c].pop_front();
                        cy = rx_cyc_q[c].pop_front();
                        assert (cy == cyc - 1) else
                            report_value_error("rx latency", $sformatf("%0d", cy + 1),
                                               $sformatf("%0d", cyc));
                        if (!rx_in_fr[c]) begin
                            rx_ts_hold[c] = i_rx_ts[c];
                        end
                        er = ref_rx(ea, rx_ts_hold[c]);
                        assert (o_rx_axis[c] == er) else
                            report_value_error("rx beat", $sformatf("%h", er),
                                               $sformatf("%h", o_rx_axis[c]));
                        rx_in_fr[c] = !ea.eop;
                    end
                end else if (rx_cyc_q[c].size() > 0 && rx_cyc_q[c][0] < cyc - 1) begin
                    report_failure("receive beat missing one cycle after input");
                end
                if (i_rx_avst_valid[c] && !held[c]) begin
                    rx_exp_q[c].push_back(i_rx_avst[c]);
                    rx_cyc_q[c].push_back(cyc);
                end
            end
        end
    end

    initial begin
        i_rst                = 1'b1;
        i_lanes_stable       = '1;
        i_ehip_ready         = '1;
        i_tx_axis            = '0;
        i_tx_valid           = '0;
        i_tx_avst_ready      = '1;
        i_tx_ts_report       = '0;
        i_tx_ts_report_valid = '0;
        i_rx_avst            = '0;
        i_rx_avst_valid      = '0;
        i_rx_ts              = '0;
        bp_on                = 1'b0;
        rep_on               = '0;
        held                 = '1;
        for (int c = 0; c < NC; c++) begin
            tx_in_fr[c]   = 1'b0;
            rx_in_fr[c]   = 1'b0;
            rx_ts_hold[c] = '0;
        end
        repeat (3) @(negedge i_mac_clk);
        i_rst = 1'b0;
        while (o_mac_rst != '0) @(posedge i_mac_clk);
        @(negedge i_mac_clk);
        held   = '0;
        rep_on = '1;

        test_name = "tx conversion";
        fork
            repeat (20) send_tx_frame(0);
            repeat (20) send_tx_frame(1);
        join

        test_name = "tx back-pressure";
        bp_on = 1'b1;
        fork
            repeat (20) send_tx_frame(0);
            repeat (20) send_tx_frame(1);
        join
        bp_on = 1'b0;

        test_name = "rx conversion";
        fork
            repeat (20) send_rx_frame(0);
            repeat (20) send_rx_frame(1);
        join

        // Lanes of channel 1 drop while channel 0 keeps running.
        test_name = "reset gating";
        rep_on[1] = 1'b0;
        @(negedge i_mac_clk);
        held[1]           = 1'b1;
        i_lanes_stable[1] = 1'b0;
        fork
            begin
                repeat (10) send_tx_frame(0);
                repeat (10) send_rx_frame(0);
            end
            begin
                @(posedge i_mac_clk);
                @(negedge i_mac_clk);
                i_tx_valid[1]      = 1'b1;
                i_rx_avst_valid[1] = 1'b1;
                rep_on[1]          = 1'b1;
                repeat (40) begin
                    i_tx_axis[1].tdata = rnd(64);
                    i_rx_avst[1].data  = rnd(64);
                    @(posedge i_mac_clk);
                    assert (o_mac_rst[1]) else
                        report_failure("channel 1 reset dropped while its lanes are down");
                    @(negedge i_mac_clk);
                end
                i_tx_valid[1]      = 1'b0;
                i_rx_avst_valid[1] = 1'b0;
                rep_on[1]          = 1'b0;
            end
        join
        @(negedge i_mac_clk);
        i_lanes_stable[1] = 1'b1;
        repeat (4) begin
            @(posedge i_mac_clk);
            assert (o_mac_rst[1]) else
                report_failure("channel 1 reset released too early");
        end
        @(posedge i_mac_clk);
        assert (!o_mac_rst[1]) else
            report_failure("channel 1 reset still high 4 cycles after lanes came back");
        @(negedge i_mac_clk);
        held[1]   = 1'b0;
        rep_on[1] = 1'b1;

        test_name = "timestamp report";
        repeat (50) @(negedge i_mac_clk);

        test_name = "drain";
        rep_on = '0;
        repeat (4) @(negedge i_mac_clk);
        for (int c = 0; c < NC; c++) begin
            assert (tx_sent_q[c].size() == 0 && rx_exp_q[c].size() == 0) else
                report_failure("beats were sent but never seen at the outputs");
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: vlog.f
ptp_pkg.sv
mac_if_pkg.sv
mac_reset_sync.sv
mac_tx_axis2avst.sv
mac_rx_avst2axis.sv
mac_rx_ts_insert.sv
mac_channel.sv
mac_dual_wrapper.sv
tb_mac_dual_wrapper.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the MAC adaptation layer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_mac_dual_wrapper -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
